//--- source/gpu_settings.svh
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// screen size, one byte per axis
`define WIDTH_BITS 8   // x coordinate width
`define HEIGHT_BITS 8  // y coordinate width

// colour is 4 bits per channel, 12-bit rgb
`define CHANNEL_BITS 4

// command queue entries
// kept a power of two so the pointers wrap cleanly
`define FIFO_DEPTH 4

`endif

//--- source/gpu_geom_pkg.sv
`include "gpu_settings.svh"

// pixel geometry and colour types
package gpu_geom_pkg;

  // screen positions
  typedef logic [`WIDTH_BITS-1:0] x_coord_t;   // column
  typedef logic [`HEIGHT_BITS-1:0] y_coord_t;  // row

  // one channel of an rgb colour
  typedef logic [`CHANNEL_BITS-1:0] channel_t;

endpackage

//--- source/gpu_cmd_pkg.sv
// command and dispatch types
package gpu_cmd_pkg;

  // drawing opcodes, any other code is treated as a no-op
  typedef enum logic [3:0] {
    OP_LINE = 4'h4,  // bresenham line from (x1,y1) to (x2,y2)
    OP_FILL = 4'h5   // filled rectangle with corners (x1,y1) and (x2,y2)
  } opcode_t;

  // dispatch fsm
  typedef enum logic [1:0] {
    IDLE,   // waiting for a queued command
    START,  // head entry latched, engine kicked this cycle
    BUSY    // engine drawing, wait for its done
  } ctrl_state_t;

endpackage

//--- source/gpu_cmd_fifo.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module gpu_cmd_fifo
  import gpu_geom_pkg::*;
  import gpu_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  input  logic     push_i,
  input  logic     pop_i,
  input  opcode_t  opcode_i,
  input  x_coord_t x1_i,
  input  y_coord_t y1_i,
  input  x_coord_t x2_i,
  input  y_coord_t y2_i,
  input  channel_t r_i,
  input  channel_t g_i,
  input  channel_t b_i,
  output opcode_t  opcode_o,
  output x_coord_t x1_o,
  output y_coord_t y1_o,
  output x_coord_t x2_o,
  output y_coord_t y2_o,
  output channel_t r_o,
  output channel_t g_o,
  output channel_t b_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int AW = $clog2(`FIFO_DEPTH);

  // one array per field
  opcode_t  op_mem [`FIFO_DEPTH];
  x_coord_t x1_mem [`FIFO_DEPTH];
  y_coord_t y1_mem [`FIFO_DEPTH];
  x_coord_t x2_mem [`FIFO_DEPTH];
  y_coord_t y2_mem [`FIFO_DEPTH];
  channel_t r_mem [`FIFO_DEPTH];
  channel_t g_mem [`FIFO_DEPTH];
  channel_t b_mem [`FIFO_DEPTH];

  logic [AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AW:0]   count_q;  // occupancy, 0..depth

  // storage write
  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      op_mem[wr_ptr_q] <= opcode_i;
      x1_mem[wr_ptr_q] <= x1_i;
      y1_mem[wr_ptr_q] <= y1_i;
      x2_mem[wr_ptr_q] <= x2_i;
      y2_mem[wr_ptr_q] <= y2_i;
      r_mem[wr_ptr_q]  <= r_i;
      g_mem[wr_ptr_q]  <= g_i;
      b_mem[wr_ptr_q]  <= b_i;
    end
  end

  // pointers and count, push and pop may coincide
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == AW'(`FIFO_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == AW'(`FIFO_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none, or both at once
      endcase
    end
  end

  // head entry, fall-through, no read latency
  assign opcode_o = op_mem[rd_ptr_q];
  assign x1_o     = x1_mem[rd_ptr_q];
  assign y1_o     = y1_mem[rd_ptr_q];
  assign x2_o     = x2_mem[rd_ptr_q];
  assign y2_o     = y2_mem[rd_ptr_q];
  assign r_o      = r_mem[rd_ptr_q];
  assign g_o      = g_mem[rd_ptr_q];
  assign b_o      = b_mem[rd_ptr_q];

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (AW+1)'(`FIFO_DEPTH));

  // the sender has no back-pressure except full_o
  a_no_overflow: assert property (@(posedge clk) disable iff (!n_rst)
    full_o |-> !push_i || pop_i);
  // controller only pops a command it has been working on
  a_no_underflow: assert property (@(posedge clk) disable iff (!n_rst)
    empty_o |-> !pop_i);

endmodule

//--- source/gpu_controller.sv
`timescale 1ns/1ps

module gpu_controller
  import gpu_geom_pkg::*;
  import gpu_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  input  opcode_t  opcode_i,  // queue head
  input  x_coord_t x1_i,
  input  y_coord_t y1_i,
  input  x_coord_t x2_i,
  input  y_coord_t y2_i,
  input  channel_t r_i,
  input  channel_t g_i,
  input  channel_t b_i,
  input  logic     empty_i,
  input  logic     line_done_i,
  input  logic     fill_done_i,
  input  logic     line_px_valid_i,
  input  x_coord_t line_px_x_i,
  input  y_coord_t line_px_y_i,
  input  logic     fill_px_valid_i,
  input  x_coord_t fill_px_x_i,
  input  y_coord_t fill_px_y_i,
  output logic     pop_o,
  output x_coord_t x1_o,  // operands shared by both engines
  output y_coord_t y1_o,
  output x_coord_t x2_o,
  output y_coord_t y2_o,
  output logic     line_start_o,
  output logic     fill_start_o,
  output logic     px_valid_o,
  output x_coord_t px_x_o,
  output y_coord_t px_y_o,
  output channel_t px_r_o,
  output channel_t px_g_o,
  output channel_t px_b_o,
  output logic     busy_o
);

  ctrl_state_t state_q, state_d;
  opcode_t     op_q;            // opcode of the command in flight
  channel_t    r_q, g_q, b_q;   // its colour

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // latch the head entry when leaving IDLE
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && !empty_i)
    begin
      op_q <= opcode_i;
      x1_o <= x1_i;
      y1_o <= y1_i;
      x2_o <= x2_i;
      y2_o <= y2_i;
      r_q  <= r_i;
      g_q  <= g_i;
      b_q  <= b_i;
    end
  end

  always_comb
  begin
    state_d      = state_q;
    pop_o        = 1'b0;
    line_start_o = 1'b0;
    fill_start_o = 1'b0;
    case (state_q)
      IDLE:
        if (!empty_i)
          state_d = START;
      START:
        case (op_q)
          OP_LINE:
          begin
            line_start_o = 1'b1;
            state_d      = BUSY;
          end
          OP_FILL:
          begin
            fill_start_o = 1'b1;
            state_d      = BUSY;
          end
          default:
          begin
            pop_o   = 1'b1;  // no-op, drop it straight away
            state_d = IDLE;
          end
        endcase
      BUSY:
        if (line_done_i || fill_done_i)
        begin
          pop_o   = 1'b1;  // command finished
          state_d = IDLE;
        end
      default: state_d = IDLE;
    endcase
  end

  // merge pixel streams, only one engine runs at a time
  assign px_valid_o = line_px_valid_i | fill_px_valid_i;
  assign px_x_o     = line_px_valid_i ? line_px_x_i : fill_px_x_i;
  assign px_y_o     = line_px_valid_i ? line_px_y_i : fill_px_y_i;
  assign px_r_o     = r_q;
  assign px_g_o     = g_q;
  assign px_b_o     = b_q;

  assign busy_o = (state_q != IDLE) || !empty_i;

  a_one_engine: assert property (@(posedge clk) disable iff (!n_rst)
    !(line_px_valid_i && fill_px_valid_i));
  a_no_idle_done: assert property (@(posedge clk) disable iff (!n_rst)
    (state_q == IDLE) |-> !(line_done_i || fill_done_i));

endmodule

//--- source/gpu_line_engine.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module gpu_line_engine
  import gpu_geom_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  input  logic     start_i,
  input  x_coord_t x1_i,
  input  y_coord_t y1_i,
  input  x_coord_t x2_i,
  input  y_coord_t y2_i,
  output logic     px_valid_o,
  output x_coord_t px_x_o,
  output y_coord_t px_y_o,
  output logic     done_o
);

  // error width, wide axis plus sign and headroom
  localparam int EW = ((`WIDTH_BITS > `HEIGHT_BITS) ? `WIDTH_BITS : `HEIGHT_BITS) + 2;

  x_coord_t x_q, x2_q, dx_q;  // current x, end x, |x2-x1|
  y_coord_t y_q, y2_q, dy_q;  // current y, end y, |y2-y1|
  logic     sx_q, sy_q;       // 1 when stepping down the axis
  logic     active_q;

  logic signed [EW-1:0] err_q, err_d;
  logic signed [EW-1:0] dx_e, dy_e;
  logic signed [EW:0]   e2;  // doubled error
  logic step_x, step_y, at_end;
  x_coord_t dx_in;
  y_coord_t dy_in;

  // magnitudes of the start operands
  assign dx_in = (x2_i >= x1_i) ? x2_i - x1_i : x1_i - x2_i;
  assign dy_in = (y2_i >= y1_i) ? y2_i - y1_i : y1_i - y2_i;

  assign dx_e = EW'(dx_q);
  assign dy_e = EW'(dy_q);
  assign e2   = {err_q, 1'b0};

  assign step_x = (e2 >= -dy_e);  // move along x
  assign step_y = (e2 <= dx_e);   // move along y
  assign err_d  = err_q - (step_x ? dy_e : '0) + (step_y ? dx_e : '0);
  assign at_end = (x_q == x2_q) && (y_q == y2_q);

  // control
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      active_q <= 1'b0;
      done_o   <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
        active_q <= 1'b1;
      else if (active_q && at_end)
      begin
        active_q <= 1'b0;  // end point shown this cycle
        done_o   <= 1'b1;
      end
    end
  end

  // walk state
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      x_q   <= x1_i;
      y_q   <= y1_i;
      x2_q  <= x2_i;
      y2_q  <= y2_i;
      dx_q  <= dx_in;
      dy_q  <= dy_in;
      sx_q  <= (x2_i < x1_i);
      sy_q  <= (y2_i < y1_i);
      err_q <= EW'(dx_in) - EW'(dy_in);  // dx - dy
    end
    else if (active_q && !at_end)
    begin
      err_q <= err_d;
      if (step_x)
        x_q <= sx_q ? x_q - 1'b1 : x_q + 1'b1;
      if (step_y)
        y_q <= sy_q ? y_q - 1'b1 : y_q + 1'b1;
    end
  end

  assign px_valid_o = active_q;  // one pixel per active cycle
  assign px_x_o     = x_q;
  assign px_y_o     = y_q;

endmodule

//--- source/gpu_fill_engine.sv
`timescale 1ns/1ps

module gpu_fill_engine
  import gpu_geom_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  input  logic     start_i,
  input  x_coord_t x1_i,
  input  y_coord_t y1_i,
  input  x_coord_t x2_i,
  input  y_coord_t y2_i,
  output logic     px_valid_o,
  output x_coord_t px_x_o,
  output y_coord_t px_y_o,
  output logic     done_o
);

  x_coord_t x_q, xmin_q, xmax_q;
  y_coord_t y_q, ymax_q;
  logic     active_q;
  logic     row_end, last_px;

  assign row_end = (x_q == xmax_q);
  assign last_px = row_end && (y_q == ymax_q);

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      active_q <= 1'b0;
      done_o   <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
        active_q <= 1'b1;
      else if (active_q && last_px)
      begin
        active_q <= 1'b0;
        done_o   <= 1'b1;  // one cycle after the last pixel
      end
    end
  end

  // raster scan, corners normalized on start
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      xmin_q <= (x1_i < x2_i) ? x1_i : x2_i;
      xmax_q <= (x1_i < x2_i) ? x2_i : x1_i;
      ymax_q <= (y1_i < y2_i) ? y2_i : y1_i;
      x_q    <= (x1_i < x2_i) ? x1_i : x2_i;  // top-left corner first
      y_q    <= (y1_i < y2_i) ? y1_i : y2_i;
    end
    else if (active_q && !last_px)
    begin
      if (row_end)
      begin
        x_q <= xmin_q;  // next row
        y_q <= y_q + 1'b1;
      end
      else
        x_q <= x_q + 1'b1;
    end
  end

  assign px_valid_o = active_q;
  assign px_x_o     = x_q;
  assign px_y_o     = y_q;

endmodule

//--- source/gpu_top.sv
`timescale 1ns/1ps

module gpu_top
  import gpu_geom_pkg::*;
  import gpu_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  input  logic     cmd_valid_i,
  input  opcode_t  opcode_i,
  input  x_coord_t x1_i,
  input  y_coord_t y1_i,
  input  x_coord_t x2_i,
  input  y_coord_t y2_i,
  input  channel_t r_i,
  input  channel_t g_i,
  input  channel_t b_i,
  output logic     cmd_full_o,
  output logic     px_valid_o,
  output x_coord_t px_x_o,
  output y_coord_t px_y_o,
  output channel_t px_r_o,
  output channel_t px_g_o,
  output channel_t px_b_o,
  output logic     busy_o
);

  // queue head
  opcode_t  q_op;
  x_coord_t q_x1, q_x2;
  y_coord_t q_y1, q_y2;
  channel_t q_r, q_g, q_b;
  logic     q_empty, q_pop;

  // operands to engines
  x_coord_t op_x1, op_x2;
  y_coord_t op_y1, op_y2;
  logic     line_start, fill_start;

  // engine pixel streams
  logic     line_valid, line_done, fill_valid, fill_done;
  x_coord_t line_x, fill_x;
  y_coord_t line_y, fill_y;

  gpu_cmd_fifo u_fifo (
    .clk(clk), .n_rst(n_rst), .push_i(cmd_valid_i), .pop_i(q_pop),
    .opcode_i(opcode_i), .x1_i(x1_i), .y1_i(y1_i), .x2_i(x2_i), .y2_i(y2_i),
    .r_i(r_i), .g_i(g_i), .b_i(b_i),
    .opcode_o(q_op), .x1_o(q_x1), .y1_o(q_y1), .x2_o(q_x2), .y2_o(q_y2),
    .r_o(q_r), .g_o(q_g), .b_o(q_b), .empty_o(q_empty), .full_o(cmd_full_o)
  );

  gpu_controller u_ctrl (
    .clk(clk), .n_rst(n_rst),
    .opcode_i(q_op), .x1_i(q_x1), .y1_i(q_y1), .x2_i(q_x2), .y2_i(q_y2),
    .r_i(q_r), .g_i(q_g), .b_i(q_b), .empty_i(q_empty),
    .line_done_i(line_done), .fill_done_i(fill_done),
    .line_px_valid_i(line_valid), .line_px_x_i(line_x), .line_px_y_i(line_y),
    .fill_px_valid_i(fill_valid), .fill_px_x_i(fill_x), .fill_px_y_i(fill_y),
    .pop_o(q_pop), .x1_o(op_x1), .y1_o(op_y1), .x2_o(op_x2), .y2_o(op_y2),
    .line_start_o(line_start), .fill_start_o(fill_start),
    .px_valid_o(px_valid_o), .px_x_o(px_x_o), .px_y_o(px_y_o),
    .px_r_o(px_r_o), .px_g_o(px_g_o), .px_b_o(px_b_o), .busy_o(busy_o)
  );

  gpu_line_engine u_line (
    .clk(clk), .n_rst(n_rst), .start_i(line_start),
    .x1_i(op_x1), .y1_i(op_y1), .x2_i(op_x2), .y2_i(op_y2),
    .px_valid_o(line_valid), .px_x_o(line_x), .px_y_o(line_y), .done_o(line_done)
  );

  gpu_fill_engine u_fill (
    .clk(clk), .n_rst(n_rst), .start_i(fill_start),
    .x1_i(op_x1), .y1_i(op_y1), .x2_i(op_x2), .y2_i(op_y2),
    .px_valid_o(fill_valid), .px_x_o(fill_x), .px_y_o(fill_y), .done_o(fill_done)
  );

endmodule

//--- bench/gpu_tb.sv
`timescale 1ns/1ps
`include "gpu_settings.svh"

module gpu_tb
  import gpu_geom_pkg::*;
  import gpu_cmd_pkg::*;
();

  logic     clk, n_rst;
  logic     cmd_valid, cmd_full;
  opcode_t  cmd_op;
  x_coord_t cmd_x1, cmd_x2;
  y_coord_t cmd_y1, cmd_y2;
  channel_t cmd_r, cmd_g, cmd_b;
  logic     px_valid, busy;
  x_coord_t px_x;
  y_coord_t px_y;
  channel_t px_r, px_g, px_b;

  // expected pixel stream as filled by the model
  x_coord_t exp_x[$];
  y_coord_t exp_y[$];
  channel_t exp_r[$], exp_g[$], exp_b[$];
  x_coord_t mon_x;  // head of the expected list
  y_coord_t mon_y;
  channel_t mon_r, mon_g, mon_b;

  int unsigned rng_state = 5877;
  int    value_errs = 0, extra_errs = 0, other_errs = 0;
  int    total_px = 0, num_cmds = 0;  // sizes the watchdog
  int    wd_cycles = 0;
  bit    saw_full;
  string test_name = "reset";

  gpu_top dut (
    .clk(clk), .n_rst(n_rst), .cmd_valid_i(cmd_valid), .opcode_i(cmd_op),
    .x1_i(cmd_x1), .y1_i(cmd_y1), .x2_i(cmd_x2), .y2_i(cmd_y2),
    .r_i(cmd_r), .g_i(cmd_g), .b_i(cmd_b), .cmd_full_o(cmd_full),
    .px_valid_o(px_valid), .px_x_o(px_x), .px_y_o(px_y),
    .px_r_o(px_r), .px_g_o(px_g), .px_b_o(px_b), .busy_o(busy)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  // lcg that hands out its upper bits
  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) & 32'h7fff;
  endfunction

  function automatic int pick(int n);
    return int'(next_rand() % n);
  endfunction

  function automatic channel_t rand_channel();
    return channel_t'(next_rand());
  endfunction

  task automatic check_coord(input x_coord_t ex, input y_coord_t ey,
                             input x_coord_t ax, input y_coord_t ay);
    if (ax !== ex || ay !== ey)
    begin
      $display("ERR %s pixel expected (%0d,%0d) actual (%0d,%0d)", test_name, ex, ey, ax, ay);
      value_errs++;
    end
  endtask

  task automatic check_colour(input channel_t er, input channel_t eg, input channel_t eb,
                              input channel_t ar, input channel_t ag, input channel_t ab);
    if (ar !== er || ag !== eg || ab !== eb)
    begin
      $display("ERR %s colour expected %h%h%h actual %h%h%h", test_name, er, eg, eb, ar, ag, ab);
      value_errs++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic push_pixel(input int x, input int y,
                            input channel_t cr, input channel_t cg, input channel_t cb);
    exp_x.push_back(x_coord_t'(x));
    exp_y.push_back(y_coord_t'(y));
    exp_r.push_back(cr);
    exp_g.push_back(cg);
    exp_b.push_back(cb);
    total_px++;
  endtask

  // integer bresenham where err starts at dx minus dy as magnitudes
  task automatic add_line_pixels(input int xa, input int ya, input int xb, input int yb,
                                 input channel_t cr, input channel_t cg, input channel_t cb);
    int dx, dy, sx, sy, err, e2, x, y;
    bit last;
    dx   = (xb >= xa) ? xb - xa : xa - xb;
    dy   = (yb >= ya) ? yb - ya : ya - yb;
    sx   = (xb >= xa) ? 1 : -1;
    sy   = (yb >= ya) ? 1 : -1;
    err  = dx - dy;
    x    = xa;
    y    = ya;
    last = 1'b0;
    while (!last)
    begin
      push_pixel(x, y, cr, cg, cb);
      last = (x == xb) && (y == yb);  // end point included
      e2   = 2 * err;
      if (e2 >= -dy)
      begin
        err -= dy;
        x   += sx;
      end
      if (e2 <= dx)
      begin
        err += dx;
        y   += sy;
      end
    end
  endtask

  // rows top to bottom and each row left to right
  task automatic add_fill_pixels(input int xa, input int ya, input int xb, input int yb,
                                 input channel_t cr, input channel_t cg, input channel_t cb);
    int xlo, xhi, ylo, yhi;
    xlo = (xa < xb) ? xa : xb;
    xhi = (xa < xb) ? xb : xa;
    ylo = (ya < yb) ? ya : yb;
    yhi = (ya < yb) ? yb : ya;
    for (int y = ylo; y <= yhi; y++)
      for (int x = xlo; x <= xhi; x++)
        push_pixel(x, y, cr, cg, cb);
  endtask

  // called 1 ns after a rising edge and returns at the same phase
  task automatic send_cmd(input opcode_t op, input int xa, input int ya, input int xb,
                          input int yb, input channel_t cr, input channel_t cg,
                          input channel_t cb);
    while (cmd_full)  // no push into a full queue
    begin
      saw_full = 1'b1;
      @(posedge clk);
      #1;
    end
    if (op == OP_LINE)
      add_line_pixels(xa, ya, xb, yb, cr, cg, cb);
    else if (op == OP_FILL)
      add_fill_pixels(xa, ya, xb, yb, cr, cg, cb);
    num_cmds++;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_x1    = x_coord_t'(xa);
    cmd_y1    = y_coord_t'(ya);
    cmd_x2    = x_coord_t'(xb);
    cmd_y2    = y_coord_t'(yb);
    cmd_r     = cr;
    cmd_g     = cg;
    cmd_b     = cb;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic send_random(input opcode_t op, input int base, input int span);
    send_cmd(op, base + pick(span), base + pick(span), base + pick(span), base + pick(span),
             rand_channel(), rand_channel(), rand_channel());
  endtask

  // wait for busy_o to drop with all pixels out by then
  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (busy)
    begin
      $display("%s: busy_o still high after %0d cycles", test_name, limit);
      other_errs++;
    end
    else if (exp_x.size() != 0)
    begin
      $display("%s: busy_o fell with %0d pixels still expected", test_name, exp_x.size());
      other_errs++;
    end
    @(posedge clk);
    #1;
  endtask

  // pixel monitor sampling mid-cycle
  always @(negedge clk)
  begin
    if (n_rst && px_valid)
    begin
      if (exp_x.size() == 0)
      begin
        $display("%s: pixel (%0d,%0d) arrived when none was expected", test_name, px_x, px_y);
        extra_errs++;
      end
      else
      begin
        mon_x = exp_x.pop_front();
        mon_y = exp_y.pop_front();
        mon_r = exp_r.pop_front();
        mon_g = exp_g.pop_front();
        mon_b = exp_b.pop_front();
        check_coord(mon_x, mon_y, px_x, px_y);
        check_colour(mon_r, mon_g, mon_b, px_r, px_g, px_b);
      end
    end
  end

  // watchdog whose limit grows with the work handed to the dut
  initial
  begin
    while (wd_cycles <= total_px + 20 * num_cmds + 100)
    begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("watchdog expired after %0d cycles in %s, the run did not finish", wd_cycles,
             test_name);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int ma, mi, ddx, ddy, xa, ya, code;
    n_rst     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_LINE;
    cmd_x1    = '0;
    cmd_y1    = '0;
    cmd_x2    = '0;
    cmd_y2    = '0;
    cmd_r     = '0;
    cmd_g     = '0;
    cmd_b     = '0;
    saw_full  = 1'b0;
    repeat (10) @(posedge clk);
    #1 n_rst = 1'b1;

    test_name = "idle";  // no commands and no activity
    repeat (20)
    begin
      @(negedge clk);
      check_bit("px_valid_o", 1'b0, px_valid);
      check_bit("busy_o", 1'b0, busy);
    end
    @(posedge clk);
    #1;

    test_name = "line_octants";
    for (int oct = 0; oct < 8; oct++)
    begin
      ma  = pick(12);
      mi  = pick(12);
      if (mi > ma)
      begin
        ddx = ma;  // swap so ma is the major axis
        ma  = mi;
        mi  = ddx;
      end
      ddx = oct[0] ? ma : mi;
      ddy = oct[0] ? mi : ma;
      if (oct[1])
        ddx = -ddx;
      if (oct[2])
        ddy = -ddy;
      xa = 40 + pick(8);
      ya = 40 + pick(8);
      send_cmd(OP_LINE, xa, ya, xa + ddx, ya + ddy, rand_channel(), rand_channel(),
               rand_channel());
      wait_idle(200);
    end
    send_cmd(OP_LINE, 17, 9, 17, 9, 4'h3, 4'hc, 4'h5);  // single point
    wait_idle(200);

    test_name = "fill";
    for (int i = 0; i < 6; i++)
    begin
      send_random(OP_FILL, 10, 8);  // corners land in either order
      wait_idle(200);
    end
    send_cmd(OP_FILL, 30, 25, 27, 22, 4'ha, 4'h1, 4'hf);  // bottom-right corner first
    wait_idle(200);

    test_name = "nop";
    for (int i = 0; i < 2; i++)
    begin
      code = pick(16);
      while (code == 4 || code == 5)
        code = pick(16);
      send_random(opcode_t'(code), 5, 10);
      send_random(OP_LINE, 20, 10);
      wait_idle(200);
    end

    test_name = "burst";
    saw_full = 1'b0;
    send_cmd(OP_FILL, 2, 2, 7, 7, 4'h9, 4'h6, 4'h0);  // long first shape backs up the queue
    for (int i = 0; i < 11; i++)
    begin
      if (i < `FIFO_DEPTH)  // the fill holds its entry until done
        check_bit("cmd_full_o", i == `FIFO_DEPTH - 1, cmd_full);
      case (pick(3))
        0:       send_random(OP_LINE, 50, 10);
        1:       send_random(OP_FILL, 60, 6);
        default: send_random(opcode_t'(4'ha), 0, 10);
      endcase
    end
    if (!saw_full)
    begin
      $display("burst: cmd_full_o never rose");
      other_errs++;
    end
    wait_idle(2000);

    if (exp_x.size() != 0)
    begin
      $display("%0d expected pixels never appeared", exp_x.size());
      other_errs++;
    end
    $display("errors: %0d wrong values, %0d unexpected pixels, %0d other", value_errs,
             extra_errs, other_errs);
    if (value_errs + extra_errs + other_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/gpu_geom_pkg.sv
source/gpu_cmd_pkg.sv
source/gpu_cmd_fifo.sv
source/gpu_controller.sv
source/gpu_line_engine.sv
source/gpu_fill_engine.sv
source/gpu_top.sv
bench/gpu_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := gpu_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST)) source/gpu_settings.svh
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
